// File: Bender.yml
package:
  name: tank_game

sources:
  - tank_game_pkg.sv
  - tank_control.sv
  - tank_shells.sv
  - monster_field.sv
  - pixel_renderer.sv
  - tank_game_top.sv
  - target: simulation
    files:
      - tank_game_props.sv
      - tank_game_tb.sv

// File: monster_field.sv
`timescale 1ns/10ps
`default_nettype none

module monster_field #(
	parameter int NUM_MONSTERS = 5,
	parameter tank_game_pkg::coord_t MONSTER_X0 = 10'd250,
	parameter tank_game_pkg::coord_t MONSTER_PITCH = 10'd100
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [NUM_MONSTERS-1:0] hit,
	output tank_game_pkg::coord_t   monster_x [NUM_MONSTERS],
	output logic [NUM_MONSTERS-1:0] monster_alive
);

	// monsters do not move, all of them share the row line MONSTER_Y
	// so only the column and the alive flag are stored
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			// evenly spaced row, everyone alive
			for (int k = 0; k < NUM_MONSTERS; k++) begin
				monster_x[k] <= tank_game_pkg::coord_t'(MONSTER_X0 + k * MONSTER_PITCH);
				monster_alive[k] <= 1'b1;
			end
		end else begin
			for (int k = 0; k < NUM_MONSTERS; k++) begin
				if (hit[k]) begin
					// destroyed
					// park it past the right edge where no shell can reach it
					monster_x[k] <= tank_game_pkg::MONSTER_GONE_X;
					monster_alive[k] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: pixel_renderer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_renderer #(
	parameter int NUM_SHELLS = 3,
	parameter int NUM_MONSTERS = 5
) (
	input  logic                  bright,
	input  tank_game_pkg::coord_t h_count,
	input  tank_game_pkg::coord_t v_count,
	input  tank_game_pkg::coord_t tank_x,
	input  tank_game_pkg::coord_t shell_x [NUM_SHELLS],
	input  tank_game_pkg::coord_t shell_y [NUM_SHELLS],
	input  logic [NUM_SHELLS-1:0] shell_alive,
	input  tank_game_pkg::coord_t monster_x [NUM_MONSTERS],
	output tank_game_pkg::rgb_t   rgb
);

	// sprite masks for the current beam position
	logic tank_head;
	logic tank_body;
	logic [NUM_SHELLS-1:0] shell_on;
	logic [NUM_MONSTERS-1:0] monster_on;

	// inclusive range test, kept in 10-bit arithmetic
	function automatic logic in_span(
		input tank_game_pkg::coord_t p,
		input tank_game_pkg::coord_t lo,
		input tank_game_pkg::coord_t hi
	);
		return (p >= lo) && (p <= hi);
	endfunction

	// head sits on the lines just above the body
	assign tank_head = in_span(v_count, tank_game_pkg::TANK_Y - tank_game_pkg::TANK_HEAD_H,
			tank_game_pkg::TANK_Y - 10'd1) &&
		in_span(h_count, tank_x - tank_game_pkg::TANK_HEAD_HALF_W,
			tank_x + tank_game_pkg::TANK_HEAD_HALF_W);

	// body hangs from the centre line downwards
	assign tank_body = in_span(v_count, tank_game_pkg::TANK_Y,
			tank_game_pkg::TANK_Y + tank_game_pkg::TANK_BODY_H) &&
		in_span(h_count, tank_x - tank_game_pkg::TANK_BODY_HALF_W,
			tank_x + tank_game_pkg::TANK_BODY_HALF_W);

	// 3x3 shell dot, dead slots are not drawn
	for (genvar i = 0; i < NUM_SHELLS; i++) begin : g_shell
		assign shell_on[i] = shell_alive[i] &&
			in_span(v_count, shell_y[i] - tank_game_pkg::SHELL_HALF,
				shell_y[i] + tank_game_pkg::SHELL_HALF) &&
			in_span(h_count, shell_x[i] - tank_game_pkg::SHELL_HALF,
				shell_x[i] + tank_game_pkg::SHELL_HALF);
	end

	// monsters are hidden by their parked column once destroyed
	for (genvar k = 0; k < NUM_MONSTERS; k++) begin : g_monster
		assign monster_on[k] =
			in_span(v_count, tank_game_pkg::MONSTER_Y - tank_game_pkg::MONSTER_HALF_H,
				tank_game_pkg::MONSTER_Y + tank_game_pkg::MONSTER_HALF_H) &&
			in_span(h_count, monster_x[k] - tank_game_pkg::MONSTER_HALF_W,
				monster_x[k] + tank_game_pkg::MONSTER_HALF_W);
	end

	// colour priority, shells over tank over monsters
	always_comb begin
		if (!bright) begin
			// blanking interval
			rgb = tank_game_pkg::COLOR_BLACK;
		end else if (|shell_on) begin
			rgb = tank_game_pkg::COLOR_BLUE;
		end else if (tank_head || tank_body) begin
			rgb = tank_game_pkg::COLOR_GREEN;
		end else if (|monster_on) begin
			rgb = tank_game_pkg::COLOR_RED;
		end else begin
			rgb = tank_game_pkg::COLOR_BLACK;
		end
	end

endmodule

`default_nettype wire

// File: tank_control.sv
`timescale 1ns/10ps
`default_nettype none

module tank_control #(
	parameter tank_game_pkg::coord_t TANK_STEP = 10'd2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  left,
	input  logic                  right,
	input  logic                  fire,
	output tank_game_pkg::coord_t tank_x,
	output logic                  fire_pulse
);

	// fire as sampled at the previous edge
	logic fire_q;

	// action chosen for the current cycle
	tank_game_pkg::tank_action_e action;

	// one-pulse edge detector on the already clean fire input
	// fire_pulse is high for the single cycle after fire is first seen high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fire_q <= 1'b0;
			fire_pulse <= 1'b0;
		end else begin
			fire_q <= fire;
			fire_pulse <= fire & ~fire_q;
		end
	end

	// priority pick
	// the tank stands still during the pulse cycle so the shell leaves
	// from a well defined column
	always_comb begin
		if (fire_pulse) begin
			action = tank_game_pkg::ACT_FIRE;
		end else if (right) begin
			action = tank_game_pkg::ACT_RIGHT;
		end else if (left) begin
			action = tank_game_pkg::ACT_LEFT;
		end else begin
			action = tank_game_pkg::ACT_HOLD;
		end
	end

	// tank column with lane wrap
	// the wrap only fires when the column sits exactly on a limit, as in
	// the original game, so the step must divide the lane width
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tank_x <= tank_game_pkg::TANK_X_RESET;
		end else begin
			case (action)
				tank_game_pkg::ACT_RIGHT: begin
					if (tank_x == tank_game_pkg::LANE_RIGHT) begin
						// right edge jumps to the left edge
						tank_x <= tank_game_pkg::LANE_LEFT;
					end else begin
						tank_x <= tank_x + TANK_STEP;
					end
				end
				tank_game_pkg::ACT_LEFT: begin
					if (tank_x == tank_game_pkg::LANE_LEFT) begin
						// left edge jumps to the right edge
						tank_x <= tank_game_pkg::LANE_RIGHT;
					end else begin
						tank_x <= tank_x - TANK_STEP;
					end
				end
				default: begin
					// hold and fire leave the column alone
					tank_x <= tank_x;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tank_game_pkg.sv
`default_nettype none

package tank_game_pkg;

	// one screen coordinate, wide enough for the 800x525 beam counts
	typedef logic [9:0] coord_t;

	// 4:4:4 colour, red in the top nibble
	typedef logic [11:0] rgb_t;

	// palette
	localparam rgb_t COLOR_BLACK = 12'h000;
	localparam rgb_t COLOR_GREEN = 12'h0f0;
	localparam rgb_t COLOR_BLUE = 12'h00f;
	localparam rgb_t COLOR_RED = 12'hf00;

	// tank placement and lane limits
	localparam coord_t TANK_Y = 10'd450;
	localparam coord_t TANK_X_RESET = 10'd450;
	localparam coord_t LANE_LEFT = 10'd150;
	localparam coord_t LANE_RIGHT = 10'd800;

	// shells retire on this line or the one below it
	localparam coord_t SHELL_TOP_Y = 10'd32;

	// monster row, and the parking column for a destroyed monster
	localparam coord_t MONSTER_Y = 10'd100;
	localparam coord_t MONSTER_GONE_X = 10'd1000;

	// sprite extents around the centre point
	localparam coord_t TANK_BODY_HALF_W = 10'd10;
	localparam coord_t TANK_BODY_H = 10'd10;
	localparam coord_t TANK_HEAD_HALF_W = 10'd2;
	localparam coord_t TANK_HEAD_H = 10'd5;
	localparam coord_t MONSTER_HALF_W = 10'd10;
	localparam coord_t MONSTER_HALF_H = 10'd5;
	localparam coord_t SHELL_HALF = 10'd1;

	// what the tank does in one cycle, fire first, then right, then left
	typedef enum logic [1:0] {
		ACT_HOLD,
		ACT_LEFT,
		ACT_RIGHT,
		ACT_FIRE
	} tank_action_e;

endpackage

`default_nettype wire

// File: tank_game_props.sv
`timescale 1ns/10ps
`default_nettype none

module tank_game_props #(
	parameter int NUM_MONSTERS = 5,
	parameter bit SHELL_SIDE = 1'b0
) (
	input logic                    clk,
	input logic                    rst,
	input logic                    fire_pulse,
	input logic [NUM_MONSTERS-1:0] hit,
	input logic [NUM_MONSTERS-1:0] monster_alive
);

	if (SHELL_SIDE) begin : g_shell
		// pulse seen as the tank action it forces
		tank_game_pkg::tank_action_e act;

		assign act = fire_pulse ? tank_game_pkg::ACT_FIRE : tank_game_pkg::ACT_HOLD;

		// edge detector gives a single cycle
		a_single_pulse: assert property (@(posedge clk) disable iff (rst)
			act == tank_game_pkg::ACT_FIRE |=> act != tank_game_pkg::ACT_FIRE)
			else $error("fire_pulse high on two cycles in a row");
	end else begin : g_field
		// only reset brings a monster back
		a_no_revive: assert property (@(posedge clk) disable iff (rst)
			(monster_alive & ~$past(monster_alive)) == '0)
			else $error("monster_alive rose outside reset");

		// parked monsters are out of reach
		a_hit_live: assert property (@(posedge clk) disable iff (rst)
			(hit & ~monster_alive) == '0)
			else $error("hit reported for a dead monster");
	end

endmodule

// shell side watches the fire pulse
bind tank_shells tank_game_props #(.NUM_MONSTERS(NUM_MONSTERS), .SHELL_SIDE(1'b1)) u_shell_props (
	.clk(clk), .rst(rst), .fire_pulse(fire_pulse), .hit(hit), .monster_alive('1)
);

// monster row side watches hits against the alive flags
bind monster_field tank_game_props #(.NUM_MONSTERS(NUM_MONSTERS)) u_field_props (
	.clk(clk), .rst(rst), .fire_pulse(1'b0), .hit(hit), .monster_alive(monster_alive)
);

`default_nettype wire

// File: tank_game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tank_game_tb;

	// cycle budget of the five tests, and slack on top of it
	localparam int BUDGET = 2800;
	localparam int MARGIN = 500;

	logic clk, rst, left, right, fire, bright;
	tank_game_pkg::coord_t h_count;
	tank_game_pkg::coord_t v_count;
	tank_game_pkg::rgb_t rgb;
	logic [4:0] monster_alive;

	// reference model state, advanced once per rising edge
	int m_tx;
	logic m_fq;
	logic m_pulse;
	logic [4:0] m_alive;
	logic [2:0] m_sa;
	int m_sx [3];
	int m_sy [3];
	int m_mx [5];
	// beam follows the shells and the tank while scan is set
	logic scan;
	int phase = 0;
	int checks, errors, test_errs, n, col, prev_col, seed;

	tank_game_top DUT (
		.clk(clk), .rst(rst), .left(left), .right(right), .fire(fire),
		.bright(bright), .h_count(h_count), .v_count(v_count),
		.rgb(rgb), .monster_alive(monster_alive)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// expected colour at one beam point, shells over tank over monsters
	function automatic tank_game_pkg::rgb_t ref_rgb(input int h, input int v, input logic br);
		if (!br) begin
			return tank_game_pkg::COLOR_BLACK;
		end
		for (int i = 0; i < 3; i++) begin
			if (m_sa[i] && h >= m_sx[i] - 1 && h <= m_sx[i] + 1 &&
				v >= m_sy[i] - 1 && v <= m_sy[i] + 1) begin
				return tank_game_pkg::COLOR_BLUE;
			end
		end
		// head on lines 445..449, body on 450..460
		if ((v >= 445 && v <= 449 && h >= m_tx - 2 && h <= m_tx + 2) ||
			(v >= 450 && v <= 460 && h >= m_tx - 10 && h <= m_tx + 10)) begin
			return tank_game_pkg::COLOR_GREEN;
		end
		for (int k = 0; k < 5; k++) begin
			if (v >= 95 && v <= 105 && h >= m_mx[k] - 10 && h <= m_mx[k] + 10) begin
				return tank_game_pkg::COLOR_RED;
			end
		end
		return tank_game_pkg::COLOR_BLACK;
	endfunction

	always @(posedge clk) begin : model
		logic [4:0] hits;
		logic [2:0] shell_hit;
		logic taken;
		if (rst) begin
			m_tx = 450;
			m_fq = 1'b0;
			m_pulse = 1'b0;
			m_alive = 5'h1f;
			m_sa = '0;
			for (int i = 0; i < 3; i++) begin
				m_sx[i] = 450;
				m_sy[i] = 450;
			end
			for (int k = 0; k < 5; k++) begin
				m_mx[k] = 250 + 100 * k;
			end
		end else begin
			hits = '0;
			shell_hit = '0;
			taken = 1'b0;
			// collisions on the state before this edge
			for (int i = 0; i < 3; i++) begin
				for (int k = 0; k < 5; k++) begin
					if (m_sa[i] && m_sy[i] == 100 &&
						m_sx[i] >= m_mx[k] - 10 && m_sx[i] <= m_mx[k] + 10) begin
						hits[k] = 1'b1;
						shell_hit[i] = 1'b1;
					end
				end
			end
			for (int i = 0; i < 3; i++) begin
				if (m_sa[i]) begin
					if (m_sy[i] == 32 || m_sy[i] == 33 || shell_hit[i]) begin
						m_sa[i] = 1'b0;
						m_sy[i] = 450;
					end else begin
						m_sy[i] = m_sy[i] - 1;
					end
				end else if (m_pulse && !taken) begin
					// lowest free slot, launched from the old column
					m_sa[i] = 1'b1;
					m_sx[i] = m_tx;
					taken = 1'b1;
				end
			end
			for (int k = 0; k < 5; k++) begin
				if (hits[k]) begin
					m_alive[k] = 1'b0;
					m_mx[k] = 1000;
				end
			end
			// tank holds still in the pulse cycle
			if (!m_pulse && right) begin
				m_tx = (m_tx == 800) ? 150 : m_tx + 2;
			end else if (!m_pulse && left) begin
				m_tx = (m_tx == 150) ? 800 : m_tx - 2;
			end
			m_pulse = fire && !m_fq;
			m_fq = fire;
		end
		if (scan) begin
			phase = (phase + 1) % 4;
			h_count <= (phase < 3) ? 10'(m_sx[phase]) : 10'(m_tx);
			v_count <= (phase < 3) ? 10'(m_sy[phase]) : 10'd455;
		end
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %0h expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	// continuous compare against the model
	always @(negedge clk) begin
		if (!rst) begin
			check("rgb", rgb, ref_rgb(h_count, v_count, bright));
			check("monster_alive", monster_alive, m_alive);
		end
	end

	task automatic probe(input int h, input int v, input logic br, input tank_game_pkg::rgb_t exp);
		@(posedge clk);
		h_count <= 10'(h);
		v_count <= 10'(v);
		bright <= br;
		@(negedge clk);
		check("rgb", rgb, exp);
	endtask

	task automatic do_reset();
		@(posedge clk);
		rst <= 1'b1;
		left <= 1'b0;
		right <= 1'b0;
		fire <= 1'b0;
		scan <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	// tank from 450 down to column 300, half way between monsters 0 and 1
	task automatic go_to_300();
		@(posedge clk);
		left <= 1'b1;
		scan <= 1'b1;
		repeat (75) @(posedge clk);
		left <= 1'b0;
	endtask

	task automatic press_fire();
		@(posedge clk);
		fire <= 1'b1;
		@(posedge clk);
		fire <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		$display("%s: %s", name, (errors == test_errs) ? "pass" : "FAIL");
		test_errs = errors;
	endtask

	initial begin
		repeat (BUDGET + MARGIN) @(posedge clk);
		$display("timeout: the tests ran past their cycle budget");
		$display("Test failures found");
		$finish;
	end

	initial begin
		seed = $urandom(72670);
		checks = 0;
		errors = 0;
		test_errs = 0;
		rst = 1'b1;
		{left, right, fire, scan} = '0;
		bright = 1'b1;
		h_count = '0;
		v_count = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// 1: static picture after reset
		probe(450, 455, 1'b1, tank_game_pkg::COLOR_GREEN);
		for (int k = 0; k < 5; k++) begin
			probe(250 + 100 * k, 100, 1'b1, tank_game_pkg::COLOR_RED);
		end
		probe(600, 300, 1'b1, tank_game_pkg::COLOR_BLACK);
		probe(450, 455, 1'b0, tank_game_pkg::COLOR_BLACK);
		probe(250, 100, 1'b0, tank_game_pkg::COLOR_BLACK);
		probe(10, 10, 1'b1, tank_game_pkg::COLOR_BLACK);
		check("monster_alive", monster_alive, 5'h1f);
		finish_test("reset picture");

		// 2: right past 800 -> 150, then left past 150 -> 800
		n = 180 + $urandom % 60;
		col = 450;
		repeat (n) col = (col == 800) ? 150 : col + 2;
		@(posedge clk);
		right <= 1'b1;
		scan <= 1'b1;
		repeat (n) @(posedge clk);
		right <= 1'b0;
		scan <= 1'b0;
		probe(col, 455, 1'b1, tank_game_pkg::COLOR_GREEN);
		probe(450, 455, 1'b1, tank_game_pkg::COLOR_BLACK);
		n = 70 + $urandom % 40;
		prev_col = col;
		repeat (n) col = (col == 150) ? 800 : col - 2;
		@(posedge clk);
		left <= 1'b1;
		scan <= 1'b1;
		repeat (n) @(posedge clk);
		left <= 1'b0;
		scan <= 1'b0;
		probe(col, 455, 1'b1, tank_game_pkg::COLOR_GREEN);
		probe(prev_col, 455, 1'b1, tank_game_pkg::COLOR_BLACK);
		finish_test("movement and wrap");

		// 3: fire held with right, tank keeps moving after the pulse
		do_reset();
		go_to_300();
		// one right step lands before the pulse cycle, so the shell leaves from 302
		fire <= 1'b1;
		right <= 1'b1;
		// launch two edges after this one, then 417 rises reach line 33
		repeat (418) @(posedge clk);
		scan <= 1'b0;
		probe(302, 33, 1'b1, tank_game_pkg::COLOR_BLUE);
		// retired on the next edge instead of rising to line 32
		probe(302, 32, 1'b1, tank_game_pkg::COLOR_BLACK);
		repeat (60) @(posedge clk);
		fire <= 1'b0;
		right <= 1'b0;
		@(negedge clk);
		check("monster_alive", monster_alive, 5'h1f);
		finish_test("one shell per press");

		// 4: shot from 450 hits monster 2
		do_reset();
		@(posedge clk);
		scan <= 1'b1;
		press_fire();
		n = 0;
		while (monster_alive[2] && n < 400) begin
			@(negedge clk);
			n++;
		end
		// pulse, launch, 350 lines of rise, then the hit edge
		check("hit cycle", n, 2 + (450 - 100) + 1);
		scan <= 1'b0;
		probe(450, 100, 1'b1, tank_game_pkg::COLOR_BLACK);
		@(posedge clk);
		scan <= 1'b1;
		press_fire();
		repeat (430) @(posedge clk);
		@(negedge clk);
		check("monster_alive", monster_alive, 5'b11011);
		finish_test("hit destroys a monster");

		// 5: four quick presses, only three slots
		do_reset();
		go_to_300();
		repeat (4) begin
			press_fire();
			repeat (1 + $urandom % 4) @(posedge clk);
		end
		repeat (425) @(posedge clk);
		fire <= 1'b1;
		@(posedge clk);
		fire <= 1'b0;
		scan <= 1'b0;
		repeat (10) @(posedge clk);
		probe(300, 440, 1'b1, tank_game_pkg::COLOR_BLUE);
		@(posedge clk);
		scan <= 1'b1;
		repeat (430) @(posedge clk);
		finish_test("slot limit");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tank_game_top.sv
`timescale 1ns/10ps
`default_nettype none

module tank_game_top #(
	parameter int NUM_SHELLS = 3,
	parameter int NUM_MONSTERS = 5,
	parameter tank_game_pkg::coord_t MONSTER_X0 = 10'd250,
	parameter tank_game_pkg::coord_t MONSTER_PITCH = 10'd100,
	parameter tank_game_pkg::coord_t TANK_STEP = 10'd2
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    left,
	input  logic                    right,
	input  logic                    fire,
	input  logic                    bright,
	input  tank_game_pkg::coord_t   h_count,
	input  tank_game_pkg::coord_t   v_count,
	output tank_game_pkg::rgb_t     rgb,
	output logic [NUM_MONSTERS-1:0] monster_alive
);

	// tank to shells
	tank_game_pkg::coord_t tank_x;
	logic fire_pulse;

	// shell slots, read by the renderer
	tank_game_pkg::coord_t shell_x [NUM_SHELLS];
	tank_game_pkg::coord_t shell_y [NUM_SHELLS];
	logic [NUM_SHELLS-1:0] shell_alive;

	// monster row and the hit feedback into it
	tank_game_pkg::coord_t monster_x [NUM_MONSTERS];
	logic [NUM_MONSTERS-1:0] hit;

	tank_control #(
		.TANK_STEP(TANK_STEP)
	) u_tank_control (
		.clk(clk),
		.rst(rst),
		.left(left),
		.right(right),
		.fire(fire),
		.tank_x(tank_x),
		.fire_pulse(fire_pulse)
	);

	tank_shells #(
		.NUM_SHELLS(NUM_SHELLS),
		.NUM_MONSTERS(NUM_MONSTERS)
	) u_tank_shells (
		.clk(clk),
		.rst(rst),
		.fire_pulse(fire_pulse),
		.tank_x(tank_x),
		.monster_x(monster_x),
		.shell_x(shell_x),
		.shell_y(shell_y),
		.shell_alive(shell_alive),
		.hit(hit)
	);

	monster_field #(
		.NUM_MONSTERS(NUM_MONSTERS),
		.MONSTER_X0(MONSTER_X0),
		.MONSTER_PITCH(MONSTER_PITCH)
	) u_monster_field (
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.monster_x(monster_x),
		.monster_alive(monster_alive)
	);

	// zero latency, the beam counters feed straight through to rgb
	pixel_renderer #(
		.NUM_SHELLS(NUM_SHELLS),
		.NUM_MONSTERS(NUM_MONSTERS)
	) u_pixel_renderer (
		.bright(bright),
		.h_count(h_count),
		.v_count(v_count),
		.tank_x(tank_x),
		.shell_x(shell_x),
		.shell_y(shell_y),
		.shell_alive(shell_alive),
		.monster_x(monster_x),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// File: tank_shells.sv
`timescale 1ns/10ps
`default_nettype none

module tank_shells #(
	parameter int NUM_SHELLS = 3,
	parameter int NUM_MONSTERS = 5
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    fire_pulse,
	input  tank_game_pkg::coord_t   tank_x,
	input  tank_game_pkg::coord_t   monster_x [NUM_MONSTERS],
	output tank_game_pkg::coord_t   shell_x [NUM_SHELLS],
	output tank_game_pkg::coord_t   shell_y [NUM_SHELLS],
	output logic [NUM_SHELLS-1:0]   shell_alive,
	output logic [NUM_MONSTERS-1:0] hit
);

	// one-hot slot chosen for a launch this cycle
	logic [NUM_SHELLS-1:0] launch;
	// slot collided with some monster this cycle
	logic [NUM_SHELLS-1:0] shell_hit;
	// slot sits on the retire lines
	logic [NUM_SHELLS-1:0] at_top;

	// lowest numbered dead slot takes the shot
	// with every slot busy the pulse is dropped
	always_comb begin
		logic taken;
		taken = 1'b0;
		launch = '0;
		for (int i = 0; i < NUM_SHELLS; i++) begin
			if (fire_pulse && !shell_alive[i] && !taken) begin
				launch[i] = 1'b1;
				taken = 1'b1;
			end
		end
	end

	// retire window is two lines tall
	always_comb begin
		for (int i = 0; i < NUM_SHELLS; i++) begin
			at_top[i] = (shell_y[i] == tank_game_pkg::SHELL_TOP_Y) ||
				(shell_y[i] == tank_game_pkg::SHELL_TOP_Y + 10'd1);
		end
	end

	// every live shell against every monster column, on the monster row only
	// destroyed monsters are parked off the lane so they never match again
	always_comb begin
		tank_game_pkg::coord_t lo;
		tank_game_pkg::coord_t hi;
		hit = '0;
		shell_hit = '0;
		for (int i = 0; i < NUM_SHELLS; i++) begin
			for (int k = 0; k < NUM_MONSTERS; k++) begin
				lo = monster_x[k] - tank_game_pkg::MONSTER_HALF_W;
				hi = monster_x[k] + tank_game_pkg::MONSTER_HALF_W;
				if (shell_alive[i] && (shell_y[i] == tank_game_pkg::MONSTER_Y) &&
					(shell_x[i] >= lo) && (shell_x[i] <= hi)) begin
					hit[k] = 1'b1;
					shell_hit[i] = 1'b1;
				end
			end
		end
	end

	// slot state
	// a dead slot keeps the column of its last launch and rests on the tank line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < NUM_SHELLS; i++) begin
				shell_alive[i] <= 1'b0;
				shell_x[i] <= tank_game_pkg::TANK_X_RESET;
				shell_y[i] <= tank_game_pkg::TANK_Y;
			end
		end else begin
			for (int i = 0; i < NUM_SHELLS; i++) begin
				if (shell_alive[i]) begin
					if (at_top[i] || shell_hit[i]) begin
						// back to the pool
						shell_alive[i] <= 1'b0;
						shell_y[i] <= tank_game_pkg::TANK_Y;
					end else begin
						// rise one line per clock
						shell_y[i] <= shell_y[i] - 10'd1;
					end
				end else begin
					shell_y[i] <= tank_game_pkg::TANK_Y;
					if (launch[i]) begin
						shell_alive[i] <= 1'b1;
						shell_x[i] <= tank_x;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
tank_game_pkg.sv
tank_control.sv
tank_shells.sv
monster_field.sv
pixel_renderer.sv
tank_game_top.sv
tank_game_props.sv
tank_game_tb.sv
